// ==== sdram_patterns.txt ====
# op (W or R), word address, active-low byte mask, data, all hex
# reads carry a mask and data field that the controller ignores
W 0000010 0 11111111
W 0000011 0 22222222
R 0000010 0 00000000
R 0000011 0 00000000
W 0000010 a aabbccdd
R 0000010 0 00000000
W 0000400 0 33333333
W 1000020 0 44444444
W 0001800 0 55555555
R 0000400 0 00000000
R 1000020 0 00000000
R 0001800 0 00000000
R 0002000 0 00000000
W 0000011 5 99887766
R 0000011 0 00000000

// ==== all.f ====
+incdir+.
sdram_types_pkg.sv
sdram_fsm_pkg.sv
sdram_req_fifo.sv
sdram_init_refresh.sv
sdram_cmd_fsm.sv
sdram_read_capture.sv
sdram_ctrl.sv
sdram_model.sv
sdram_ctrl_asserts.sv
tb_sdram_ctrl.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        = tb_sdram_ctrl
FILELIST   = all.f
SIM_FLAGS  = --binary --timing --assert
LINT_FLAGS = --lint-only --timing --assert
LOG        = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -qF '*** PASSED ***' $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// ==== tb_sdram_ctrl.sv ====
// sdram controller testbench: init order, pattern traffic, back-pressure and refresh rate
`timescale 1ns/100ps
`include "sdram_params.svh"

module tb_sdram_ctrl;
  import sdram_types_pkg::*;
  import sdram_fsm_pkg::*;

  localparam int TIMEOUT = 20000;  // cycles per wait

  logic   clk;
  logic   reset_n;
  haddr_t addr;
  be_n_t  be_n;
  data_t  data;
  logic   rd_n;
  logic   wr_n;
  logic   waitrequest;
  data_t  rd_data;
  logic   rd_valid;
  logic   sd_cs_n, sd_ras_n, sd_cas_n, sd_we_n;
  row_t   sd_addr;
  bank_t  sd_ba;
  be_n_t  sd_dqm;
  data_t  sd_dq_out;
  logic   sd_dq_oe;
  data_t  sd_dq_in;
  sd_cmd_t pin_cmd;

  data_t  ref_mem [haddr_t];  // reference memory
  data_t  exp_q [$];
  haddr_t acc_q [$];          // every request in issue order
  row_t   open_row [4];
  logic   op_rnw [$];
  haddr_t op_addr [$];
  be_n_t  op_be_n [$];
  data_t  op_data [$];
  int     errors, tests_run, tests_failed;
  int     init_step, refresh_cnt;
  logic   saw_wait, timed_out;

  sdram_ctrl UUT (
    .clk(clk), .reset_n(reset_n), .i_addr(addr), .i_be_n(be_n), .i_data(data),
    .i_rd_n(rd_n), .i_wr_n(wr_n), .o_waitrequest(waitrequest), .o_rd_data(rd_data),
    .o_rd_valid(rd_valid), .o_sd_cs_n(sd_cs_n), .o_sd_ras_n(sd_ras_n),
    .o_sd_cas_n(sd_cas_n), .o_sd_we_n(sd_we_n), .o_sd_addr(sd_addr), .o_sd_ba(sd_ba),
    .o_sd_dqm(sd_dqm), .o_sd_dq(sd_dq_out), .o_sd_dq_oe(sd_dq_oe), .i_sd_dq(sd_dq_in)
  );

  sdram_model u_model (
    .clk(clk), .i_cs_n(sd_cs_n), .i_ras_n(sd_ras_n), .i_cas_n(sd_cas_n), .i_we_n(sd_we_n),
    .i_addr(sd_addr), .i_ba(sd_ba), .i_dqm(sd_dqm), .i_dq(sd_dq_out), .i_dq_oe(sd_dq_oe),
    .o_dq(sd_dq_in)
  );

  bind sdram_ctrl sdram_ctrl_asserts u_asserts (
    .clk(clk), .reset_n(reset_n), .o_sd_cs_n(o_sd_cs_n), .o_sd_ras_n(o_sd_ras_n),
    .o_sd_cas_n(o_sd_cas_n), .o_sd_we_n(o_sd_we_n), .o_sd_dq_oe(o_sd_dq_oe)
  );

  assign pin_cmd = sd_cmd_t'({sd_cs_n, sd_ras_n, sd_cas_n, sd_we_n});

  initial
    clk = 1'b0;
  always #5 clk = ~clk;

  // old word with enabled bytes replaced
  function automatic data_t merge_bytes(input data_t old_w, input data_t new_w, input be_n_t m);
    data_t w;
    w = old_w;
    for (int b = 0; b < 4; b++)
      if (!m[b])
        w[8*b +: 8] = new_w[8*b +: 8];
    return w;
  endfunction

  task automatic finish_test(input string name, input int err_start);
    tests_run++;
    if (errors != err_start)
    begin
      tests_failed++;
      $display("test %s: fail, %0d errors", name, errors - err_start);
    end
    else
      $display("test %s: ok", name);
  endtask

  task automatic note_timeout(input string what);
    errors++;
    timed_out = 1'b1;
    $display("timeout while waiting for %s", what);
  endtask

  // called on a rising edge, returns on the edge that accepted the request
  task automatic send_op(input logic rnw, input haddr_t a, input be_n_t m, input data_t d);
    int n;
    n = 0;
    rd_n <= ~rnw;
    wr_n <= rnw;
    addr <= a;
    be_n <= m;
    data <= d;
    @(posedge clk);
    while (waitrequest && n < TIMEOUT)
    begin
      saw_wait = 1'b1;
      n++;
      @(posedge clk);
    end
    if (waitrequest)
      note_timeout("request acceptance");
    else
    begin
      acc_q.push_back(a);
      if (rnw)
        exp_q.push_back(ref_mem.exists(a) ? ref_mem[a] : '0);
      else
        ref_mem[a] = merge_bytes(ref_mem.exists(a) ? ref_mem[a] : '0, d, m);
    end
  endtask

  // pin monitor and read scoreboard
  always @(posedge clk)
  begin
    if (reset_n)
    begin
      if (init_step < 4)
      begin
        if (pin_cmd == CMD_PRECHARGE && init_step == 0)
          init_step <= 1;
        else if (pin_cmd == CMD_REFRESH && (init_step == 1 || init_step == 2))
          init_step <= init_step + 1;
        else if (pin_cmd == CMD_LOAD_MODE && init_step == 3)
        begin
          init_step <= 4;
          if (sd_addr != 13'h030)
          begin
            errors++;
            $display("ERR o_sd_addr: got %h expected %h", sd_addr, 13'h030);
          end
        end
        else if (pin_cmd != CMD_NOP && pin_cmd != CMD_INHIBIT)
        begin
          errors++;
          $display("command %s out of order during init", pin_cmd.name());
        end
      end
      else
      begin
        if (pin_cmd == CMD_REFRESH)
          refresh_cnt <= refresh_cnt + 1;
        if (pin_cmd == CMD_ACTIVE)
          open_row[sd_ba] = sd_addr;
        if (pin_cmd == CMD_READ || pin_cmd == CMD_WRITE)
        begin
          if (acc_q.size() == 0)
          begin
            errors++;
            $display("access command with no request outstanding");
          end
          else
          begin
            if (sd_ba != {acc_q[0][24], acc_q[0][10]})
            begin
              errors++;
              $display("ERR o_sd_ba: got %h expected %h", sd_ba, {acc_q[0][24], acc_q[0][10]});
            end
            if (open_row[sd_ba] != acc_q[0][23:11])
            begin
              errors++;
              $display("ERR o_sd_addr row: got %h expected %h", open_row[sd_ba],
                       acc_q[0][23:11]);
            end
            if (sd_addr[9:0] != acc_q[0][9:0])
            begin
              errors++;
              $display("ERR o_sd_addr: got %h expected %h", sd_addr[9:0], acc_q[0][9:0]);
            end
            void'(acc_q.pop_front());
          end
        end
      end
    end
    if (rd_valid)
    begin
      if (exp_q.size() == 0)
      begin
        errors++;
        $display("read valid with no read outstanding");
      end
      else
      begin
        if (rd_data != exp_q[0])
        begin
          errors++;
          $display("ERR o_rd_data: got %h expected %h", rd_data, exp_q[0]);
        end
        void'(exp_q.pop_front());
      end
    end
  end

  initial
  begin
    int fd, n, e0, r0;
    string line;
    logic [7:0] op;
    haddr_t a;
    be_n_t m;
    data_t d;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    init_step = 0;
    refresh_cnt = 0;
    saw_wait = 1'b0;
    timed_out = 1'b0;
    reset_n = 1'b1;
    addr = '0;
    be_n = '1;
    data = '0;
    rd_n = 1'b1;
    wr_n = 1'b1;

    fd = $fopen("sdram_patterns.txt", "r");
    if (fd == 0)
    begin
      errors++;
      $display("cannot open sdram_patterns.txt");
    end
    else
    begin
      while (!$feof(fd))
      begin
        n = $fgets(line, fd);
        if (n > 0 && line.len() > 1 && line[0] != "#")
          if ($sscanf(line, "%c %h %h %h", op, a, m, d) == 4)
          begin
            op_rnw.push_back(op == "R");
            op_addr.push_back(a);
            op_be_n.push_back(m);
            op_data.push_back(d);
          end
      end
      $fclose(fd);
    end

    #1 reset_n = 1'b0;
    repeat (3) @(posedge clk);
    reset_n <= 1'b1;

    // init sequence up to the mode load, any activate before it is out of order
    e0 = errors;
    n = 0;
    while (init_step < 4 && n < TIMEOUT)
    begin
      n++;
      @(posedge clk);
    end
    if (init_step < 4)
      note_timeout("init sequence");
    finish_test("init order", e0);

    // pattern traffic, issued back to back
    e0 = errors;
    if (!timed_out)
    begin
      for (int i = 0; i < op_rnw.size(); i++)
        send_op(op_rnw[i], op_addr[i], op_be_n[i], op_data[i]);
      rd_n <= 1'b1;
      wr_n <= 1'b1;
      n = 0;
      while ((exp_q.size() != 0 || acc_q.size() != 0) && n < TIMEOUT)
      begin
        n++;
        @(posedge clk);
      end
      if (exp_q.size() != 0 || acc_q.size() != 0)
        note_timeout("outstanding requests");
    end
    finish_test("write, read, byte merge and address map", e0);

    e0 = errors;
    if (!saw_wait)
    begin
      errors++;
      $display("waitrequest never rose during the burst");
    end
    finish_test("back-pressure", e0);

    // idle refresh rate
    e0 = errors;
    r0 = refresh_cnt;
    repeat (5000) @(posedge clk);
    if (refresh_cnt - r0 < 3)
    begin
      errors++;
      $display("only %0d refreshes in 5000 idle cycles", refresh_cnt - r0);
    end
    finish_test("refresh", e0);

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== sdram_ctrl_asserts.sv ====
// sdram pin protocol checks: inhibit during reset, data drive only with write
`timescale 1ns/100ps

module sdram_ctrl_asserts (
  input logic clk,
  input logic reset_n,
  input logic o_sd_cs_n,
  input logic o_sd_ras_n,
  input logic o_sd_cas_n,
  input logic o_sd_we_n,
  input logic o_sd_dq_oe
);
  import sdram_fsm_pkg::*;

  logic [3:0] cmd;

  assign cmd = {o_sd_cs_n, o_sd_ras_n, o_sd_cas_n, o_sd_we_n};

  a_reset_inhibit: assert property (@(posedge clk) !reset_n |-> cmd == CMD_INHIBIT)
    else $error("command pins not inhibit during reset");

  a_reset_oe: assert property (@(posedge clk) !reset_n |-> !o_sd_dq_oe)
    else $error("data bus driven during reset");

  // bus only driven in a write cycle
  a_oe_write: assert property (@(posedge clk) disable iff (!reset_n)
    o_sd_dq_oe |-> cmd == CMD_WRITE)
    else $error("data bus driven without a write command");

endmodule

// ==== sdram_model.sv ====
// sdram memory model: decodes pin commands, stores words and returns reads at cas latency 3
`timescale 1ns/100ps
`include "sdram_params.svh"

module sdram_model (
  input  logic                   clk,
  input  logic                   i_cs_n,
  input  logic                   i_ras_n,
  input  logic                   i_cas_n,
  input  logic                   i_we_n,
  input  sdram_types_pkg::row_t  i_addr,
  input  sdram_types_pkg::bank_t i_ba,
  input  sdram_types_pkg::be_n_t i_dqm,
  input  sdram_types_pkg::data_t i_dq,
  input  logic                   i_dq_oe,
  output sdram_types_pkg::data_t o_dq
);
  import sdram_types_pkg::*;
  import sdram_fsm_pkg::*;

  sd_cmd_t     cmd;
  row_t        open_row [4];  // one open row per bank
  data_t       mem [logic [24:0]];
  data_t       rd_s1;
  data_t       rd_s2;
  data_t       word;
  logic [24:0] key;

  assign cmd = sd_cmd_t'({i_cs_n, i_ras_n, i_cas_n, i_we_n});

  always @(posedge clk)
  begin
    key = {i_ba, open_row[i_ba], i_addr[9:0]};
    word = mem.exists(key) ? mem[key] : '0;
    rd_s2 <= rd_s1;
    o_dq  <= rd_s2;  // third edge after the command was seen
    case (cmd)
      CMD_ACTIVE:
        open_row[i_ba] <= i_addr;
      CMD_WRITE:
      begin
        for (int b = 0; b < 4; b++)
          if (!i_dqm[b] && i_dq_oe)
            word[8*b +: 8] = i_dq[8*b +: 8];
        mem[key] = word;
      end
      CMD_READ:
        rd_s1 <= word;
      default:
        rd_s1 <= '0;
    endcase
  end

endmodule

// ==== sdram_ctrl.sv ====
// sdram controller top: host port, request fifo, scheduler, command fsm and read capture
`timescale 1ns/100ps

module sdram_ctrl (
  input  logic                    clk,
  input  logic                    reset_n,
  input  sdram_types_pkg::haddr_t i_addr,
  input  sdram_types_pkg::be_n_t  i_be_n,
  input  sdram_types_pkg::data_t  i_data,
  input  logic                    i_rd_n,
  input  logic                    i_wr_n,
  output logic                    o_waitrequest,
  output sdram_types_pkg::data_t  o_rd_data,
  output logic                    o_rd_valid,
  output logic                    o_sd_cs_n,
  output logic                    o_sd_ras_n,
  output logic                    o_sd_cas_n,
  output logic                    o_sd_we_n,
  output sdram_types_pkg::row_t   o_sd_addr,
  output sdram_types_pkg::bank_t  o_sd_ba,
  output sdram_types_pkg::be_n_t  o_sd_dqm,
  output sdram_types_pkg::data_t  o_sd_dq,
  output logic                    o_sd_dq_oe,
  input  sdram_types_pkg::data_t  i_sd_dq
);
  import sdram_types_pkg::*;
  import sdram_fsm_pkg::*;

  logic     head_rnw;
  haddr_t   head_addr;
  be_n_t    head_be_n;
  data_t    head_data;
  logic     fifo_empty;
  logic     pop;
  logic     init_done;
  sd_cmd_t  init_cmd;
  row_t     init_addr;
  logic     refresh_req;
  logic     refresh_ack;
  sd_cmd_t  sd_cmd;

  assign {o_sd_cs_n, o_sd_ras_n, o_sd_cas_n, o_sd_we_n} = sd_cmd;

  // reads are stored with every byte enabled
  sdram_req_fifo u_req_fifo (
    .clk         (clk),
    .reset_n     (reset_n),
    .i_wr        ((~i_wr_n | ~i_rd_n) & ~o_waitrequest),
    .i_wr_rnw    (i_wr_n),
    .i_wr_addr   (i_addr),
    .i_wr_be_n   (i_wr_n ? be_n_t'('0) : i_be_n),
    .i_wr_data   (i_data),
    .i_pop       (pop),
    .o_head_rnw  (head_rnw),
    .o_head_addr (head_addr),
    .o_head_be_n (head_be_n),
    .o_head_data (head_data),
    .o_empty     (fifo_empty),
    .o_full      (o_waitrequest)
  );

  sdram_init_refresh u_init_refresh (
    .clk           (clk),
    .reset_n       (reset_n),
    .i_refresh_ack (refresh_ack),
    .o_init_done   (init_done),
    .o_init_cmd    (init_cmd),
    .o_init_addr   (init_addr),
    .o_refresh_req (refresh_req)
  );

  sdram_cmd_fsm u_cmd_fsm (
    .clk           (clk),
    .reset_n       (reset_n),
    .i_head_rnw    (head_rnw),
    .i_head_addr   (head_addr),
    .i_head_be_n   (head_be_n),
    .i_head_data   (head_data),
    .i_empty       (fifo_empty),
    .i_init_done   (init_done),
    .i_init_cmd    (init_cmd),
    .i_init_addr   (init_addr),
    .i_refresh_req (refresh_req),
    .o_pop         (pop),
    .o_refresh_ack (refresh_ack),
    .o_sd_cmd      (sd_cmd),
    .o_sd_addr     (o_sd_addr),
    .o_sd_ba       (o_sd_ba),
    .o_sd_dqm      (o_sd_dqm),
    .o_sd_dq       (o_sd_dq),
    .o_sd_dq_oe    (o_sd_dq_oe)
  );

  sdram_read_capture u_read_capture (
    .clk        (clk),
    .reset_n    (reset_n),
    .i_sd_cmd   (sd_cmd),
    .i_sd_dq    (i_sd_dq),
    .o_rd_data  (o_rd_data),
    .o_rd_valid (o_rd_valid)
  );

endmodule

// ==== sdram_read_capture.sv ====
// sdram read capture: cas latency tracking and registered read data with valid
`timescale 1ns/100ps
`include "sdram_params.svh"

module sdram_read_capture (
  input  logic                   clk,
  input  logic                   reset_n,
  input  sdram_fsm_pkg::sd_cmd_t i_sd_cmd,
  input  sdram_types_pkg::data_t i_sd_dq,
  output sdram_types_pkg::data_t o_rd_data,
  output logic                   o_rd_valid
);
  import sdram_fsm_pkg::*;

  logic [`SDRAM_CAS_LAT-1:0] rd_pipe;  // one bit per cycle of latency
  logic                      rd_strobe;

  assign rd_strobe = (i_sd_cmd == CMD_READ);

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      rd_pipe    <= '0;
      o_rd_valid <= 1'b0;
    end
    else
    begin
      rd_pipe    <= {rd_pipe[`SDRAM_CAS_LAT-2:0], rd_strobe};
      o_rd_valid <= rd_pipe[`SDRAM_CAS_LAT-1];  // lines up with the data register
    end
  end

  always_ff @(posedge clk)
    o_rd_data <= i_sd_dq;

endmodule

// ==== sdram_cmd_fsm.sv ====
// sdram command fsm: row open and close, read and write issue, refresh insertion
`timescale 1ns/100ps
`include "sdram_params.svh"

module sdram_cmd_fsm (
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic                    i_head_rnw,
  input  sdram_types_pkg::haddr_t i_head_addr,
  input  sdram_types_pkg::be_n_t  i_head_be_n,
  input  sdram_types_pkg::data_t  i_head_data,
  input  logic                    i_empty,
  input  logic                    i_init_done,
  input  sdram_fsm_pkg::sd_cmd_t  i_init_cmd,
  input  sdram_types_pkg::row_t   i_init_addr,
  input  logic                    i_refresh_req,
  output logic                    o_pop,
  output logic                    o_refresh_ack,
  output sdram_fsm_pkg::sd_cmd_t  o_sd_cmd,
  output sdram_types_pkg::row_t   o_sd_addr,
  output sdram_types_pkg::bank_t  o_sd_ba,
  output sdram_types_pkg::be_n_t  o_sd_dqm,
  output sdram_types_pkg::data_t  o_sd_dq,
  output logic                    o_sd_dq_oe
);
  import sdram_types_pkg::*;
  import sdram_fsm_pkg::*;

  localparam int COL_PAD = `SDRAM_ROW_W - `SDRAM_COL_W;

  cmd_state_t state;
  cmd_state_t ret_state;  // where WAIT goes when the count runs out
  cnt_t       wait_cnt;

  // request being served
  logic       act_rnw;
  haddr_t     act_addr;
  be_n_t      act_be_n;
  data_t      act_data;

  bank_t      act_bank;
  row_t       act_row;
  col_t       act_col;
  bank_t      head_bank;
  row_t       head_row;
  logic       hit;

  // bank {a24, a10}, row a23..a11, col a9..a0
  assign act_bank  = {act_addr[`SDRAM_HADDR_W-1], act_addr[`SDRAM_COL_W]};
  assign act_row   = act_addr[`SDRAM_HADDR_W-2:`SDRAM_COL_W+1];
  assign act_col   = act_addr[`SDRAM_COL_W-1:0];
  assign head_bank = {i_head_addr[`SDRAM_HADDR_W-1], i_head_addr[`SDRAM_COL_W]};
  assign head_row  = i_head_addr[`SDRAM_HADDR_W-2:`SDRAM_COL_W+1];

  // next request can use the open row without a precharge
  assign hit = ~i_empty & (i_head_rnw == act_rnw) & (head_bank == act_bank)
               & (head_row == act_row);

  always_comb
  begin
    case (state)
      ST_IDLE:                       o_pop = i_init_done & ~i_refresh_req & ~i_empty;
      ST_READ, ST_WRITE, ST_OPEN_ROW: o_pop = hit & ~i_refresh_req;  // refresh wins
      default:                       o_pop = 1'b0;
    endcase
  end

  // every pop moves the head entry here
  always_ff @(posedge clk)
  begin
    if (o_pop)
    begin
      act_rnw  <= i_head_rnw;
      act_addr <= i_head_addr;
      act_be_n <= i_head_be_n;
      act_data <= i_head_data;
    end
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state         <= ST_IDLE;
      ret_state     <= ST_IDLE;
      wait_cnt      <= '0;
      o_sd_cmd      <= CMD_INHIBIT;
      o_sd_addr     <= '0;
      o_sd_ba       <= '0;
      o_sd_dqm      <= '0;
      o_sd_dq       <= '0;
      o_sd_dq_oe    <= 1'b0;
      o_refresh_ack <= 1'b0;
    end
    else
    begin
      o_sd_dq_oe    <= 1'b0;
      o_refresh_ack <= 1'b0;
      case (state)
        ST_IDLE:
        begin
          if (!i_init_done)
          begin
            o_sd_cmd  <= i_init_cmd;  // scheduler owns the pins during init
            o_sd_addr <= i_init_addr;
          end
          else if (i_refresh_req)
          begin
            o_sd_cmd  <= CMD_NOP;
            ret_state <= ST_AUTO_REFRESH;
            state     <= ST_PRECHARGE;
          end
          else
          begin
            o_sd_cmd <= CMD_INHIBIT;
            if (!i_empty)
              state <= ST_ACTIVATE;
          end
        end
        ST_ACTIVATE:
        begin
          o_sd_cmd  <= CMD_ACTIVE;
          o_sd_ba   <= act_bank;
          o_sd_addr <= act_row;
          wait_cnt  <= cnt_t'(`SDRAM_T_RCD);
          ret_state <= act_rnw ? ST_READ : ST_WRITE;
          state     <= ST_WAIT;
        end
        ST_WAIT:
        begin
          o_sd_cmd <= CMD_NOP;
          if (wait_cnt > cnt_t'(1))
            wait_cnt <= wait_cnt - 1'b1;
          else
            state <= ret_state;
        end
        ST_READ:
        begin
          o_sd_cmd  <= CMD_READ;
          o_sd_ba   <= act_bank;
          o_sd_addr <= {{COL_PAD{1'b0}}, act_col};  // a10 low, no auto precharge
          o_sd_dqm  <= act_be_n;
          if (!o_pop)
            state <= ST_OPEN_ROW;
        end
        ST_WRITE:
        begin
          o_sd_cmd   <= CMD_WRITE;
          o_sd_ba    <= act_bank;
          o_sd_addr  <= {{COL_PAD{1'b0}}, act_col};
          o_sd_dqm   <= act_be_n;
          o_sd_dq    <= act_data;
          o_sd_dq_oe <= 1'b1;  // data goes out with the command
          if (!o_pop)
            state <= ST_OPEN_ROW;
        end
        ST_OPEN_ROW:
        begin
          o_sd_cmd <= CMD_NOP;
          if (i_refresh_req)
          begin
            ret_state <= ST_AUTO_REFRESH;
            state     <= ST_PAUSE;
          end
          else if (o_pop)
            state <= act_rnw ? ST_READ : ST_WRITE;
          else if (!i_empty)
          begin
            // miss, close the row and start over
            ret_state <= ST_IDLE;
            state     <= ST_PAUSE;
          end
        end
        ST_PAUSE:
        begin
          o_sd_cmd <= CMD_NOP;  // write recovery
          state    <= ST_PRECHARGE;
        end
        ST_PRECHARGE:
        begin
          o_sd_cmd  <= CMD_PRECHARGE;
          o_sd_addr <= '1;  // all banks
          wait_cnt  <= cnt_t'(`SDRAM_T_RCD);  // trp matches trcd on this part
          state     <= ST_WAIT;
        end
        ST_AUTO_REFRESH:
        begin
          o_sd_cmd      <= CMD_REFRESH;
          o_refresh_ack <= 1'b1;
          wait_cnt      <= cnt_t'(`SDRAM_T_RFC);
          ret_state     <= ST_IDLE;
          state         <= ST_WAIT;
        end
        default:
        begin
          o_sd_cmd <= CMD_INHIBIT;
          state    <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

// ==== sdram_init_refresh.sv ====
// sdram init and refresh scheduler: power-up command sequence and periodic refresh requests
`timescale 1ns/100ps
`include "sdram_params.svh"

module sdram_init_refresh (
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic                   i_refresh_ack,
  output logic                   o_init_done,
  output sdram_fsm_pkg::sd_cmd_t o_init_cmd,
  output sdram_types_pkg::row_t  o_init_addr,
  output logic                   o_refresh_req
);
  import sdram_types_pkg::*;
  import sdram_fsm_pkg::*;

  localparam int REF_CNT_W = $clog2(`SDRAM_INIT_WAIT + 1);

  logic [REF_CNT_W-1:0] ref_cnt;
  logic                 cnt_zero;
  init_state_t          state;
  init_state_t          ret_state;
  cnt_t                 wait_cnt;
  cnt_t                 refs_done;

  assign cnt_zero = (ref_cnt == '0);

  // power-up wait first, refresh period after that
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      ref_cnt <= REF_CNT_W'(`SDRAM_INIT_WAIT);
    else if (cnt_zero)
      ref_cnt <= REF_CNT_W'(`SDRAM_REFRESH_PERIOD);
    else
      ref_cnt <= ref_cnt - 1'b1;
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      o_refresh_req <= 1'b0;
      o_init_done   <= 1'b0;
    end
    else
    begin
      // held until the fsm acks it
      o_refresh_req <= (cnt_zero | o_refresh_req) & ~i_refresh_ack & o_init_done;
      o_init_done   <= o_init_done | (state == INIT_DONE);
    end
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state       <= INIT_WAIT_POWERUP;
      ret_state   <= INIT_WAIT_POWERUP;
      o_init_cmd  <= CMD_INHIBIT;
      o_init_addr <= '1;
      wait_cnt    <= '0;
      refs_done   <= '0;
    end
    else
    begin
      o_init_addr <= '1;  // a10 high, precharge hits all banks
      case (state)
        INIT_WAIT_POWERUP:
        begin
          o_init_cmd <= CMD_INHIBIT;
          refs_done  <= '0;
          if (cnt_zero)
            state <= INIT_PRECHARGE_ALL;
        end
        INIT_PRECHARGE_ALL:
        begin
          o_init_cmd <= CMD_PRECHARGE;
          wait_cnt   <= cnt_t'(1);
          ret_state  <= INIT_REFRESH;
          state      <= INIT_WAIT;
        end
        INIT_REFRESH:
        begin
          o_init_cmd <= CMD_REFRESH;
          refs_done  <= refs_done + 1'b1;
          wait_cnt   <= cnt_t'(`SDRAM_T_RFC);
          if (refs_done == cnt_t'(`SDRAM_INIT_REFS - 1))
            ret_state <= INIT_LOAD_MODE;
          else
            ret_state <= INIT_REFRESH;
          state <= INIT_WAIT;
        end
        INIT_WAIT:
        begin
          o_init_cmd <= CMD_NOP;
          if (wait_cnt > cnt_t'(1))
            wait_cnt <= wait_cnt - 1'b1;
          else
            state <= ret_state;
        end
        INIT_LOAD_MODE:
        begin
          o_init_cmd  <= CMD_LOAD_MODE;
          o_init_addr <= row_t'(`SDRAM_MODE_WORD);
          wait_cnt    <= cnt_t'(`SDRAM_T_MRD);
          ret_state   <= INIT_DONE;
          state       <= INIT_WAIT;
        end
        INIT_DONE:
          o_init_cmd <= CMD_NOP;  // stays here
        default:
          state <= INIT_WAIT_POWERUP;
      endcase
    end
  end

endmodule

// ==== sdram_req_fifo.sv ====
// sdram request fifo: two-entry buffer between the host port and the command fsm
`timescale 1ns/100ps

module sdram_req_fifo (
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic                    i_wr,
  input  logic                    i_wr_rnw,
  input  sdram_types_pkg::haddr_t i_wr_addr,
  input  sdram_types_pkg::be_n_t  i_wr_be_n,
  input  sdram_types_pkg::data_t  i_wr_data,
  input  logic                    i_pop,
  output logic                    o_head_rnw,
  output sdram_types_pkg::haddr_t o_head_addr,
  output sdram_types_pkg::be_n_t  o_head_be_n,
  output sdram_types_pkg::data_t  o_head_data,
  output logic                    o_empty,
  output logic                    o_full
);
  import sdram_types_pkg::*;

  logic       rnw_mem [2];
  haddr_t     addr_mem [2];
  be_n_t      be_n_mem [2];
  data_t      data_mem [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;
  logic       do_wr;
  logic       do_pop;

  assign o_full  = (count == 2'd2);
  assign o_empty = (count == 2'd0);
  assign do_wr   = i_wr & ~o_full;
  assign do_pop  = i_pop & ~o_empty;

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end
    else
    begin
      if (do_wr)
        wr_ptr <= ~wr_ptr;
      if (do_pop)
        rd_ptr <= ~rd_ptr;
      case ({do_wr, do_pop})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (do_wr)
    begin
      rnw_mem[wr_ptr]  <= i_wr_rnw;
      addr_mem[wr_ptr] <= i_wr_addr;
      be_n_mem[wr_ptr] <= i_wr_be_n;
      data_mem[wr_ptr] <= i_wr_data;
    end
  end

  // head entry seen by the fsm
  assign o_head_rnw  = rnw_mem[rd_ptr];
  assign o_head_addr = addr_mem[rd_ptr];
  assign o_head_be_n = be_n_mem[rd_ptr];
  assign o_head_data = data_mem[rd_ptr];

endmodule

// ==== sdram_fsm_pkg.sv ====
// sdram state machine package: command codes and state encodings
package sdram_fsm_pkg;

  // {cs_n, ras_n, cas_n, we_n}
  typedef enum logic [3:0] {
    CMD_LOAD_MODE = 4'b0000,
    CMD_REFRESH   = 4'b0001,
    CMD_PRECHARGE = 4'b0010,
    CMD_ACTIVE    = 4'b0011,
    CMD_WRITE     = 4'b0100,
    CMD_READ      = 4'b0101,
    CMD_NOP       = 4'b0111,
    CMD_INHIBIT   = 4'b1111
  } sd_cmd_t;

  // power-up sequencer
  typedef enum logic [2:0] {
    INIT_WAIT_POWERUP,
    INIT_PRECHARGE_ALL,
    INIT_REFRESH,
    INIT_WAIT,
    INIT_LOAD_MODE,
    INIT_DONE
  } init_state_t;

  // main command fsm
  typedef enum logic [3:0] {
    ST_IDLE,
    ST_ACTIVATE,
    ST_WAIT,
    ST_READ,
    ST_WRITE,
    ST_PAUSE,
    ST_PRECHARGE,
    ST_AUTO_REFRESH,
    ST_OPEN_ROW
  } cmd_state_t;

endpackage

// ==== sdram_types_pkg.sv ====
// sdram types package: vector types for host side and memory bus quantities
`include "sdram_params.svh"

package sdram_types_pkg;

  // host word address {bank hi, row, bank lo, col}
  typedef logic [`SDRAM_HADDR_W-1:0] haddr_t;
  typedef logic [`SDRAM_DATA_W-1:0] data_t;

  // active low, one bit per byte lane
  typedef logic [`SDRAM_BE_W-1:0] be_n_t;

  // pin address, doubles as the row
  typedef logic [`SDRAM_ROW_W-1:0] row_t;
  typedef logic [`SDRAM_COL_W-1:0] col_t;
  typedef logic [`SDRAM_BANK_W-1:0] bank_t;

  typedef logic [2:0] cnt_t;  // wide enough for t_rfc

endpackage

// ==== sdram_params.svh ====
// sdram controller parameters: bus widths, timing counts and the mode register word
`ifndef SDRAM_PARAMS_SVH
`define SDRAM_PARAMS_SVH

// host and pin widths
`define SDRAM_HADDR_W 25
`define SDRAM_DATA_W 32
`define SDRAM_BE_W 4
`define SDRAM_ROW_W 13
`define SDRAM_COL_W 10
`define SDRAM_BANK_W 2

// power-up wait, cycles
`define SDRAM_INIT_WAIT 10000
`define SDRAM_REFRESH_PERIOD 1562  // reload value, one request per 1563 cycles

// wait counts
`define SDRAM_T_RFC 7
`define SDRAM_T_MRD 4
`define SDRAM_T_RCD 2
`define SDRAM_CAS_LAT 3

`define SDRAM_MODE_WORD 13'h030  // cas latency 3, sequential, burst length 1
`define SDRAM_INIT_REFS 2

`endif
